//--- design/cpu_pkg.sv
package cpu_pkg;

  // width of the signed immediate and of the B offset path
  localparam int OFFSET_WIDTH = 12;

  typedef logic [31:0] word_t;

  typedef enum logic [3:0] {
    OP_ALU  = 4'h0,
    OP_LDI  = 4'h1,
    OP_LD   = 4'h2,
    OP_ST   = 4'h3,
    OP_PUSH = 4'h4,
    OP_POP  = 4'h5,
    OP_BZ   = 4'h6,
    OP_JAL  = 4'h7,
    OP_JR   = 4'h8,
    OP_HALT = 4'hf
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_PASSB
  } alu_op_e;

  // 0..7 are the general registers, the rest live in special_regs
  typedef enum logic [3:0] {
    R0, R1, R2, R3, R4, R5, R6, R7,
    PC,
    SP,
    SPINC,
    SPDEC,
    LR,
    PCLINK,
    STATUS,
    NONE
  } reg_e;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } status_t;

  typedef struct packed {
    opcode_e                        opcode;
    reg_e                           rd;
    reg_e                           ra;
    reg_e                           rb;
    logic                           func_pad;
    alu_op_e                        func;
    logic signed [OFFSET_WIDTH-1:0] imm;
  } ir_t;

endpackage

//--- design/reg_bus_if.sv
`timescale 1ns/10ps

interface reg_bus_if;

  cpu_pkg::reg_e  sel_a;
  cpu_pkg::reg_e  sel_b;
  cpu_pkg::reg_e  sel_in;
  logic           oe_a;
  logic           oe_b;
  logic           ld;

  // raw register buses ahead of the filters, and the result bus
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  cpu_pkg::word_t result;

  modport ctrl (output sel_a, sel_b, sel_in, oe_a, oe_b, ld);

  modport file (input sel_a, sel_b, sel_in, oe_a, oe_b, ld, result);

  modport special (input sel_a, sel_b, sel_in, oe_a, oe_b, ld, result);

endinterface

//--- design/alu.sv
`timescale 1ns/10ps

module alu (
  input  cpu_pkg::alu_op_e op,
  input  logic             carry_in,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result,
  output cpu_pkg::status_t flags
);

  logic [32:0] wide;
  logic        carry;

  always_comb begin
    wide  = '0;
    // logic ops leave the carry as it was
    carry = carry_in;
    case (op)
      cpu_pkg::ALU_ADD: begin
        wide  = {1'b0, a} + {1'b0, b};
        carry = wide[32];
      end
      cpu_pkg::ALU_SUB: begin
        // carry set means borrow
        wide  = {1'b0, a} - {1'b0, b};
        carry = wide[32];
      end
      cpu_pkg::ALU_AND: wide[31:0] = a & b;
      cpu_pkg::ALU_OR:  wide[31:0] = a | b;
      cpu_pkg::ALU_XOR: wide[31:0] = a ^ b;
      cpu_pkg::ALU_SHL: wide[31:0] = a << b[4:0];
      cpu_pkg::ALU_SHR: wide[31:0] = a >> b[4:0];
      default:          wide[31:0] = b;
    endcase
    // a difference or an xor is zero exactly when both operands match
    if (op == cpu_pkg::ALU_SUB || op == cpu_pkg::ALU_XOR) begin
      assert ((wide[31:0] == '0) == (a == b))
        else $error("alu zero result disagrees with operand compare, a %h b %h", a, b);
    end
  end

  assign result         = wide[31:0];
  assign flags.zero     = (result == '0);
  assign flags.negative = result[31];
  assign flags.carry    = carry;

endmodule

//--- design/bus_filter.sv
`timescale 1ns/10ps

module bus_filter #(
  parameter int OFFSET_WIDTH = cpu_pkg::OFFSET_WIDTH
) (
  input  cpu_pkg::word_t                 in,
  input  cpu_pkg::word_t                 mask,
  input  logic signed [OFFSET_WIDTH-1:0] offset,
  output cpu_pkg::word_t                 out
);

  localparam int WORD_W = $bits(cpu_pkg::word_t);

  cpu_pkg::word_t masked;
  cpu_pkg::word_t offset_ext;

  assign masked     = in & mask;
  assign offset_ext = {{(WORD_W - OFFSET_WIDTH){offset[OFFSET_WIDTH-1]}}, offset};

  // mask to zero plus offset gives any small constant
  assign out = masked + offset_ext;

endmodule

//--- design/register_file.sv
`timescale 1ns/10ps

module register_file #(
  parameter int REG_COUNT = 8
) (
  input  logic           clk,
  input  logic           arst_n,
  reg_bus_if.file        bus,
  output cpu_pkg::word_t a_out,
  output cpu_pkg::word_t b_out,
  output logic           a_hit,
  output logic           b_hit
);

  localparam int IDX_W = $clog2(REG_COUNT);

  cpu_pkg::word_t   regs [REG_COUNT];
  logic [IDX_W-1:0] idx_a;
  logic [IDX_W-1:0] idx_b;
  logic [IDX_W-1:0] idx_in;
  logic             ld_hit;

  function automatic logic is_general(cpu_pkg::reg_e sel);
    return int'(sel) < REG_COUNT;
  endfunction

  assign idx_a  = bus.sel_a[IDX_W-1:0];
  assign idx_b  = bus.sel_b[IDX_W-1:0];
  assign idx_in = bus.sel_in[IDX_W-1:0];

  assign a_hit  = bus.oe_a && is_general(bus.sel_a);
  assign b_hit  = bus.oe_b && is_general(bus.sel_b);
  assign ld_hit = bus.ld && is_general(bus.sel_in);

  assign a_out = a_hit ? regs[idx_a] : '0;
  assign b_out = b_hit ? regs[idx_b] : '0;

  // ld already carries the stall qualifier from the control unit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (ld_hit) begin
      regs[idx_in] <= bus.result;
    end
  end

endmodule

//--- design/special_regs.sv
`timescale 1ns/10ps

module special_regs (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             en,
  reg_bus_if.special       bus,
  input  logic             post_inc_pc,
  input  cpu_pkg::status_t flags,
  input  logic             ld_status,
  output cpu_pkg::word_t   a_out,
  output cpu_pkg::word_t   b_out,
  output logic             a_hit,
  output logic             b_hit,
  output cpu_pkg::status_t status
);

  localparam cpu_pkg::word_t SP_RESET = 32'h0000_1000;

  cpu_pkg::word_t pc;
  cpu_pkg::word_t sp;
  cpu_pkg::word_t lr;
  logic           ld_pc;
  logic           ld_link;
  logic           ld_lr;
  logic           ld_status_reg;
  logic           sp_ld;
  logic           sp_inc;
  logic           sp_dec;

  function automatic cpu_pkg::word_t read_value(cpu_pkg::reg_e sel);
    case (sel)
      cpu_pkg::PC, cpu_pkg::PCLINK: return pc;
      cpu_pkg::SP, cpu_pkg::SPINC:  return sp;
      // pre-decrement shows the new top of stack
      cpu_pkg::SPDEC:               return sp - 32'd4;
      cpu_pkg::LR:                  return lr;
      cpu_pkg::STATUS:              return cpu_pkg::word_t'(status);
      default:                      return '0;
    endcase
  endfunction

  assign a_hit = bus.oe_a && (bus.sel_a inside {[cpu_pkg::PC : cpu_pkg::STATUS]});
  assign b_hit = bus.oe_b && (bus.sel_b inside {[cpu_pkg::PC : cpu_pkg::STATUS]});
  assign a_out = a_hit ? read_value(bus.sel_a) : '0;
  assign b_out = b_hit ? read_value(bus.sel_b) : '0;

  assign ld_pc         = bus.ld && (bus.sel_in inside {cpu_pkg::PC, cpu_pkg::PCLINK});
  assign ld_link       = bus.ld && (bus.sel_in == cpu_pkg::PCLINK);
  assign ld_lr         = bus.ld && (bus.sel_in == cpu_pkg::LR);
  assign ld_status_reg = bus.ld && (bus.sel_in == cpu_pkg::STATUS);

  // a stack read on both buses in one cycle still moves sp once
  assign sp_ld  = bus.ld && (bus.sel_in inside {cpu_pkg::SP, cpu_pkg::SPINC, cpu_pkg::SPDEC});
  assign sp_inc = (bus.oe_a && bus.sel_a == cpu_pkg::SPINC) ||
                  (bus.oe_b && bus.sel_b == cpu_pkg::SPINC);
  assign sp_dec = (bus.oe_a && bus.sel_a == cpu_pkg::SPDEC) ||
                  (bus.oe_b && bus.sel_b == cpu_pkg::SPDEC);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (en) begin
      if (ld_pc) begin
        pc <= bus.result;
      end else if (post_inc_pc) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sp <= SP_RESET;
    end else if (en) begin
      if (sp_ld) begin
        sp <= bus.result;
      end else if (sp_inc) begin
        sp <= sp + 32'd4;
      end else if (sp_dec) begin
        sp <= sp - 32'd4;
      end
    end
  end

  // link takes the pc before the jump target lands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lr <= '0;
    end else if (en) begin
      if (ld_link) begin
        lr <= pc;
      end else if (ld_lr) begin
        lr <= bus.result;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status <= '0;
    end else if (en) begin
      if (ld_status) begin
        status <= flags;
      end else if (ld_status_reg) begin
        status <= cpu_pkg::status_t'(bus.result[2:0]);
      end
    end
  end

  sp_single_adjust: assert property (
    @(posedge clk) disable iff (!arst_n) en |-> $onehot0({sp_inc, sp_dec})
  ) else $error("sp incremented and decremented in the same cycle");

endmodule

//--- design/cu.sv
`timescale 1ns/10ps

module cu #(
  parameter int OFFSET_WIDTH = cpu_pkg::OFFSET_WIDTH
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           en,
  input  cpu_pkg::ir_t                   ir,
  input  cpu_pkg::status_t               status,
  reg_bus_if.ctrl                        bus,
  output cpu_pkg::word_t                 mask_a,
  output cpu_pkg::word_t                 mask_b,
  output logic signed [OFFSET_WIDTH-1:0] offset_b,
  output cpu_pkg::alu_op_e               alu_op,
  output logic                           ld_ir,
  output logic                           ld_status,
  output logic                           post_inc_pc,
  output logic                           rd,
  output logic                           wr,
  output logic                           halted
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_HALT
  } state_e;

  state_e                         state;
  state_e                         state_next;
  logic                           armed;
  logic                           ld;
  logic                           stop;
  logic signed [OFFSET_WIDTH-1:0] imm;

  assign imm = OFFSET_WIDTH'(signed'(ir.imm));

  // first enabled edge after reset arms the fetch, so no strobe is seen in reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_FETCH;
      armed <= 1'b0;
    end else if (en) begin
      state <= state_next;
      armed <= 1'b1;
    end
  end

  always_comb begin
    case (state)
      S_FETCH: state_next = armed ? S_EXEC : S_FETCH;
      S_EXEC:  state_next = stop ? S_HALT : S_FETCH;
      default: state_next = S_HALT;
    endcase
  end

  always_comb begin
    bus.sel_a   = cpu_pkg::NONE;
    bus.sel_b   = cpu_pkg::NONE;
    bus.sel_in  = cpu_pkg::NONE;
    bus.oe_a    = 1'b0;
    bus.oe_b    = 1'b0;
    ld          = 1'b0;
    mask_a      = '0;
    mask_b      = '0;
    offset_b    = '0;
    alu_op      = cpu_pkg::ALU_PASSB;
    ld_ir       = 1'b0;
    ld_status   = 1'b0;
    post_inc_pc = 1'b0;
    rd          = 1'b0;
    wr          = 1'b0;
    stop        = 1'b0;
    case (state)
      S_FETCH: begin
        if (armed) begin
          bus.sel_b   = cpu_pkg::PC;
          bus.oe_b    = 1'b1;
          mask_b      = '1;
          rd          = 1'b1;
          ld_ir       = 1'b1;
          post_inc_pc = 1'b1;
        end
      end
      S_EXEC: begin
        // sources go on B, with A only for the second operand or store data
        case (ir.opcode)
          cpu_pkg::OP_ALU: begin
            bus.sel_a  = ir.ra;
            bus.sel_b  = ir.rb;
            bus.oe_a   = 1'b1;
            bus.oe_b   = 1'b1;
            mask_a     = '1;
            mask_b     = '1;
            alu_op     = ir.func;
            bus.sel_in = ir.rd;
            ld         = 1'b1;
            ld_status  = 1'b1;
          end
          cpu_pkg::OP_LDI: begin
            offset_b   = imm;
            bus.sel_in = ir.rd;
            ld         = 1'b1;
          end
          cpu_pkg::OP_LD, cpu_pkg::OP_ST: begin
            bus.sel_b = ir.ra;
            bus.oe_b  = 1'b1;
            mask_b    = '1;
            offset_b  = imm;
            if (ir.opcode == cpu_pkg::OP_LD) begin
              bus.sel_in = ir.rd;
              ld         = 1'b1;
              rd         = 1'b1;
            end else begin
              bus.sel_a = ir.rb;
              bus.oe_a  = 1'b1;
              mask_a    = '1;
              wr        = 1'b1;
            end
          end
          cpu_pkg::OP_PUSH: begin
            bus.sel_a = ir.rb;
            bus.oe_a  = 1'b1;
            mask_a    = '1;
            bus.sel_b = cpu_pkg::SPDEC;
            bus.oe_b  = 1'b1;
            mask_b    = '1;
            wr        = 1'b1;
          end
          cpu_pkg::OP_POP: begin
            bus.sel_b  = cpu_pkg::SPINC;
            bus.oe_b   = 1'b1;
            mask_b     = '1;
            bus.sel_in = ir.rd;
            ld         = 1'b1;
            rd         = 1'b1;
          end
          cpu_pkg::OP_BZ, cpu_pkg::OP_JAL: begin
            // pc already points past this instruction
            if (ir.opcode == cpu_pkg::OP_JAL || status.zero) begin
              bus.sel_b  = cpu_pkg::PC;
              bus.oe_b   = 1'b1;
              mask_b     = '1;
              offset_b   = imm;
              bus.sel_in = (ir.opcode == cpu_pkg::OP_JAL) ? cpu_pkg::PCLINK : cpu_pkg::PC;
              ld         = 1'b1;
            end
          end
          cpu_pkg::OP_JR: begin
            bus.sel_b  = ir.ra;
            bus.oe_b   = 1'b1;
            mask_b     = '1;
            bus.sel_in = cpu_pkg::PC;
            ld         = 1'b1;
          end
          default: stop = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // the register file has no stall input of its own
  assign bus.ld = ld && en;
  assign halted = (state == S_HALT);

  strobe_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n) !(rd && wr)
  ) else $error("rd and wr asserted together");

  strobe_hold: assert property (
    @(posedge clk) disable iff (!arst_n) !en |=> $stable({rd, wr})
  ) else $error("memory strobes changed while stalled");

endmodule

//--- design/cpu.sv
`timescale 1ns/10ps

module cpu #(
  parameter int REG_COUNT    = 8,
  parameter int OFFSET_WIDTH = cpu_pkg::OFFSET_WIDTH
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           en,
  input  cpu_pkg::word_t rdata,
  output cpu_pkg::word_t wdata,
  output cpu_pkg::word_t addr,
  output logic           rd,
  output logic           wr,
  output logic           halted
);

  reg_bus_if rbus ();

  cpu_pkg::word_t                 mask_a;
  cpu_pkg::word_t                 mask_b;
  logic signed [OFFSET_WIDTH-1:0] offset_b;
  cpu_pkg::alu_op_e               alu_op;
  logic                           ld_ir;
  logic                           ld_status;
  logic                           post_inc_pc;
  cpu_pkg::status_t               status;
  cpu_pkg::status_t               flags;
  cpu_pkg::word_t                 alu_result;
  cpu_pkg::word_t                 a_bus;
  cpu_pkg::word_t                 b_bus;
  cpu_pkg::word_t                 rf_a;
  cpu_pkg::word_t                 rf_b;
  logic                           rf_a_hit;
  logic                           rf_b_hit;
  cpu_pkg::word_t                 sr_a;
  cpu_pkg::word_t                 sr_b;
  logic                           sr_a_hit;
  logic                           sr_b_hit;
  cpu_pkg::ir_t                   ir;

  cu #(
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) i_cu (
    .clk        (clk),
    .arst_n     (arst_n),
    .en         (en),
    .ir         (ir),
    .status     (status),
    .bus        (rbus),
    .mask_a     (mask_a),
    .mask_b     (mask_b),
    .offset_b   (offset_b),
    .alu_op     (alu_op),
    .ld_ir      (ld_ir),
    .ld_status  (ld_status),
    .post_inc_pc(post_inc_pc),
    .rd         (rd),
    .wr         (wr),
    .halted     (halted)
  );

  register_file #(
    .REG_COUNT(REG_COUNT)
  ) i_register_file (
    .clk   (clk),
    .arst_n(arst_n),
    .bus   (rbus),
    .a_out (rf_a),
    .b_out (rf_b),
    .a_hit (rf_a_hit),
    .b_hit (rf_b_hit)
  );

  special_regs i_special_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .en         (en),
    .bus        (rbus),
    .post_inc_pc(post_inc_pc),
    .flags      (flags),
    .ld_status  (ld_status),
    .a_out      (sr_a),
    .b_out      (sr_b),
    .a_hit      (sr_a_hit),
    .b_hit      (sr_b_hit),
    .status     (status)
  );

  // private instruction register, on a bus when NONE is selected
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir <= '0;
    end else if (en && ld_ir) begin
      ir <= cpu_pkg::ir_t'(rbus.result);
    end
  end

  always_comb begin
    if (rf_a_hit) begin
      rbus.a = rf_a;
    end else if (sr_a_hit) begin
      rbus.a = sr_a;
    end else if (rbus.oe_a) begin
      rbus.a = cpu_pkg::word_t'(ir);
    end else begin
      rbus.a = '0;
    end
  end

  always_comb begin
    if (rf_b_hit) begin
      rbus.b = rf_b;
    end else if (sr_b_hit) begin
      rbus.b = sr_b;
    end else if (rbus.oe_b) begin
      rbus.b = cpu_pkg::word_t'(ir);
    end else begin
      rbus.b = '0;
    end
  end

  // A side never takes an offset
  bus_filter #(
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) i_filter_a (
    .in    (rbus.a),
    .mask  (mask_a),
    .offset('0),
    .out   (a_bus)
  );

  bus_filter #(
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) i_filter_b (
    .in    (rbus.b),
    .mask  (mask_b),
    .offset(offset_b),
    .out   (b_bus)
  );

  alu i_alu (
    .op      (alu_op),
    .carry_in(status.carry),
    .a       (a_bus),
    .b       (b_bus),
    .result  (alu_result),
    .flags   (flags)
  );

  // memory read data takes over the result bus during rd
  assign rbus.result = rd ? rdata : alu_result;

  assign addr  = (rd || wr) ? b_bus : '0;
  assign wdata = wr ? a_bus : '0;

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    forever #20 clk = ~clk;
  end

  // hold reset low for 3 rising edges, released on a falling edge
  task automatic apply_reset();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  endtask

endmodule

//--- dv/cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker #(
  parameter int MEM_WORDS = 2048
) (
  input logic           clk,
  input logic           arst_n,
  input logic           en,
  input logic           wr,
  input cpu_pkg::word_t addr,
  input cpu_pkg::word_t wdata,
  input cpu_pkg::word_t prog [MEM_WORDS]
);

  cpu_pkg::word_t exp_addr[$];
  cpu_pkg::word_t exp_data[$];
  cpu_pkg::word_t ref_mem [MEM_WORDS];
  cpu_pkg::word_t ref_r   [8];
  cpu_pkg::word_t ref_pc;
  cpu_pkg::word_t ref_sp;
  cpu_pkg::word_t ref_lr;
  logic           ref_z;
  string          test_name;
  bit             active = 1'b0;
  int             got = 0;
  int             test_errors = 0;
  int             checks = 0;
  int             errors = 0;
  int             tests = 0;
  int             failed_tests = 0;

  function automatic int word_index(cpu_pkg::word_t a);
    return int'((a >> 2) % MEM_WORDS);
  endfunction

  function automatic cpu_pkg::word_t read_reg(logic [3:0] code);
    if (code < 4'd8) begin
      return ref_r[code[2:0]];
    end
    case (code)
      4'd8:    return ref_pc;
      4'd9:    return ref_sp;
      4'd12:   return ref_lr;
      default: return '0;
    endcase
  endfunction

  // reference ISA model, collects every store in program order
  function automatic void build_expected();
    cpu_pkg::word_t ins;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t res;
    cpu_pkg::word_t imm;
    cpu_pkg::word_t ea;
    logic [3:0]     op;
    logic [3:0]     rdi;
    logic [3:0]     rai;
    logic [3:0]     rbi;
    logic [2:0]     fn;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = prog[i];
    end
    for (int i = 0; i < 8; i++) begin
      ref_r[i] = '0;
    end
    ref_pc = '0;
    ref_sp = 32'h0000_1000;
    ref_lr = '0;
    ref_z  = 1'b0;
    for (int step = 0; step < 1000; step++) begin
      ins    = ref_mem[word_index(ref_pc)];
      ref_pc = ref_pc + 32'd4;
      op     = ins[31:28];
      rdi    = ins[27:24];
      rai    = ins[23:20];
      rbi    = ins[19:16];
      fn     = ins[14:12];
      imm    = {{20{ins[11]}}, ins[11:0]};
      case (op)
        4'h0: begin
          a = read_reg(rai);
          b = read_reg(rbi);
          case (fn)
            3'd0:    res = a + b;
            3'd1:    res = a - b;
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            3'd4:    res = a ^ b;
            3'd5:    res = a << b[4:0];
            3'd6:    res = a >> b[4:0];
            default: res = b;
          endcase
          ref_z             = (res == '0);
          ref_r[rdi[2:0]]   = res;
        end
        4'h1: ref_r[rdi[2:0]] = imm;
        4'h2: ref_r[rdi[2:0]] = ref_mem[word_index(read_reg(rai) + imm)];
        4'h3: begin
          ea = read_reg(rai) + imm;
          exp_addr.push_back(ea);
          exp_data.push_back(read_reg(rbi));
          ref_mem[word_index(ea)] = read_reg(rbi);
        end
        4'h4: begin
          ref_sp = ref_sp - 32'd4;
          exp_addr.push_back(ref_sp);
          exp_data.push_back(read_reg(rbi));
          ref_mem[word_index(ref_sp)] = read_reg(rbi);
        end
        4'h5: begin
          ref_r[rdi[2:0]] = ref_mem[word_index(ref_sp)];
          ref_sp          = ref_sp + 32'd4;
        end
        4'h6: begin
          if (ref_z) begin
            ref_pc = ref_pc + imm;
          end
        end
        4'h7: begin
          ref_lr = ref_pc;
          ref_pc = ref_pc + imm;
        end
        4'h8: ref_pc = read_reg(rai);
        default: return;
      endcase
    end
  endfunction

  task automatic note_error(string msg);
    $display("test %s: %s", test_name, msg);
    test_errors++;
    errors++;
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
    build_expected();
    tests++;
    active = 1'b1;
  endtask

  task automatic end_test();
    active = 1'b0;
    if (got < exp_addr.size()) begin
      note_error($sformatf("missing stores, saw %0d of %0d", got, exp_addr.size()));
    end
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("test %-12s %s stores=%0d errors=%0d", test_name,
             (test_errors == 0) ? "ok" : "bad", got, test_errors);
  endtask

  // every enabled wr is one store, compared in order
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      got = 0;
    end else if (active && en && wr) begin
      checks++;
      if (got >= exp_addr.size()) begin
        note_error($sformatf("unexpected store to %h beyond the expected sequence", addr));
      end else begin
        if (addr !== exp_addr[got]) begin
          $display("FAILED test %s store %0d addr: expected %h actual %h",
                   test_name, got, exp_addr[got], addr);
          test_errors++;
          errors++;
        end
        if (wdata !== exp_data[got]) begin
          $display("FAILED test %s store %0d data: expected %h actual %h",
                   test_name, got, exp_data[got], wdata);
          test_errors++;
          errors++;
        end
      end
      got++;
    end
  end

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int MEM_WORDS = 2048;

  logic           clk;
  logic           arst_n;
  logic           en;
  cpu_pkg::word_t rdata;
  cpu_pkg::word_t wdata;
  cpu_pkg::word_t addr;
  logic           rd;
  logic           wr;
  logic           halted;
  cpu_pkg::word_t mem [MEM_WORDS];
  int             seed;
  bit             stall_mode;
  int             load_ptr;

  tb_clk_gen i_clk (
    .clk   (clk),
    .arst_n(arst_n)
  );

  cpu #(
    .REG_COUNT   (8),
    .OFFSET_WIDTH(cpu_pkg::OFFSET_WIDTH)
  ) i_dut (
    .clk   (clk),
    .arst_n(arst_n),
    .en    (en),
    .rdata (rdata),
    .wdata (wdata),
    .addr  (addr),
    .rd    (rd),
    .wr    (wr),
    .halted(halted)
  );

  cpu_checker #(
    .MEM_WORDS(MEM_WORDS)
  ) i_chk (
    .clk   (clk),
    .arst_n(arst_n),
    .en    (en),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .prog  (mem)
  );

  always @(posedge clk) begin
    if (arst_n && en && wr) begin
      mem[int'((addr >> 2) % MEM_WORDS)] = wdata;
    end
  end

  // memory answers rd from the address of the current cycle
  always @(negedge clk) begin
    if (stall_mode) begin
      en <= (($random(seed) & 3) != 0);
    end else begin
      en <= 1'b1;
    end
    rdata <= rd ? mem[int'((addr >> 2) % MEM_WORDS)] : '0;
  end

  function automatic cpu_pkg::word_t encode(logic [3:0] op, logic [3:0] rd_f,
                                            logic [3:0] ra_f, logic [3:0] rb_f,
                                            logic [2:0] fn, logic [11:0] imm);
    return {op, rd_f, ra_f, rb_f, 1'b0, fn, imm};
  endfunction

  task automatic clear_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i) * 32'h9E37_79B9;
    end
    load_ptr = 0;
  endtask

  task automatic emit(cpu_pkg::word_t w);
    mem[load_ptr] = w;
    load_ptr++;
  endtask

  task automatic wait_halted();
    int n;
    for (n = 0; n < 2000; n++) begin
      @(posedge clk);
      if (halted) begin
        break;
      end
    end
    if (n >= 2000) begin
      i_chk.note_error("timeout, cpu did not halt within 2000 cycles");
    end
  endtask

  task automatic wait_stores(int count);
    int n;
    for (n = 0; n < 2000; n++) begin
      @(negedge clk);
      if (i_chk.got >= count) begin
        break;
      end
    end
    if (n >= 2000) begin
      i_chk.note_error("timeout while waiting for the first stores");
    end
  endtask

  task automatic run_program(string name, bit stall);
    stall_mode = stall;
    i_clk.apply_reset();
    i_chk.begin_test(name);
    wait_halted();
    i_chk.end_test();
  endtask

  task automatic load_alu_program();
    clear_memory();
    for (int op = 0; op < 8; op++) begin
      emit(encode(4'h1, 4'd1, 4'd0, 4'd0, 3'd0, 12'($random(seed))));
      emit(encode(4'h1, 4'd2, 4'd0, 4'd0, 3'd0, 12'($random(seed))));
      emit(encode(4'h0, 4'd3, 4'd1, 4'd2, 3'(op), 12'd0));
      emit(encode(4'h3, 4'd0, 4'd0, 4'd3, 3'd0, 12'(12'h400 + 4 * op)));
    end
    emit(encode(4'hf, 4'd0, 4'd0, 4'd0, 3'd0, 12'd0));
  endtask

  task automatic load_ldst_program();
    clear_memory();
    mem[(32'h200 + 8) >> 2]  = $random(seed);
    mem[(32'h200 - 12) >> 2] = $random(seed);
    emit(encode(4'h1, 4'd4, 4'd0, 4'd0, 3'd0, 12'h200));
    emit(encode(4'h2, 4'd1, 4'd4, 4'd0, 3'd0, 12'd8));
    emit(encode(4'h2, 4'd2, 4'd4, 4'd0, 3'd0, -12'sd12));
    emit(encode(4'h3, 4'd0, 4'd4, 4'd1, 3'd0, -12'sd4));
    emit(encode(4'h3, 4'd0, 4'd4, 4'd2, 3'd0, 12'd16));
    emit(encode(4'h2, 4'd3, 4'd4, 4'd0, 3'd0, -12'sd4));
    emit(encode(4'h3, 4'd0, 4'd4, 4'd3, 3'd0, 12'd20));
    emit(encode(4'hf, 4'd0, 4'd0, 4'd0, 3'd0, 12'd0));
  endtask

  task automatic load_stack_program();
    clear_memory();
    for (int r = 1; r <= 3; r++) begin
      emit(encode(4'h1, 4'(r), 4'd0, 4'd0, 3'd0, 12'($random(seed))));
    end
    for (int r = 1; r <= 3; r++) begin
      emit(encode(4'h4, 4'd0, 4'd0, 4'(r), 3'd0, 12'd0));
    end
    for (int r = 5; r <= 7; r++) begin
      emit(encode(4'h5, 4'(r), 4'd0, 4'd0, 3'd0, 12'd0));
    end
    for (int r = 5; r <= 7; r++) begin
      emit(encode(4'h3, 4'd0, 4'd0, 4'(r), 3'd0, 12'(12'h300 + 4 * (r - 5))));
    end
    emit(encode(4'hf, 4'd0, 4'd0, 4'd0, 3'd0, 12'd0));
  endtask

  // taken and untaken BZ, then a JAL into a routine that returns with JR LR
  task automatic load_branch_program();
    clear_memory();
    emit(encode(4'h1, 4'd1, 4'd0, 4'd0, 3'd0, 12'd5));
    emit(encode(4'h1, 4'd2, 4'd0, 4'd0, 3'd0, 12'd5));
    emit(encode(4'h0, 4'd3, 4'd1, 4'd2, 3'd1, 12'd0));
    emit(encode(4'h6, 4'd0, 4'd0, 4'd0, 3'd0, 12'd4));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd1, 3'd0, 12'h300));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd2, 3'd0, 12'h304));
    emit(encode(4'h0, 4'd3, 4'd1, 4'd0, 3'd1, 12'd0));
    emit(encode(4'h6, 4'd0, 4'd0, 4'd0, 3'd0, 12'd4));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd1, 3'd0, 12'h308));
    emit(encode(4'h7, 4'd0, 4'd0, 4'd0, 3'd0, 12'd12));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd3, 3'd0, 12'h30c));
    emit(encode(4'hf, 4'd0, 4'd0, 4'd0, 3'd0, 12'd0));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd1, 3'd0, 12'h3f0));
    emit(encode(4'h3, 4'd0, 4'd0, 4'd2, 3'd0, 12'h310));
    emit(encode(4'h8, 4'd0, 4'd12, 4'd0, 3'd0, 12'd0));
  endtask

  initial begin
    seed       = 55;
    en         = 1'b0;
    rdata      = '0;
    stall_mode = 1'b0;
    clear_memory();

    load_alu_program();
    run_program("alu_ops", 1'b0);
    load_ldst_program();
    run_program("ld_st", 1'b0);
    load_stack_program();
    run_program("push_pop", 1'b0);
    load_branch_program();
    run_program("branches", 1'b0);
    load_branch_program();
    run_program("en_stalls", 1'b1);

    // restart in the middle of the branch program
    load_branch_program();
    stall_mode = 1'b0;
    i_clk.apply_reset();
    i_chk.begin_test("mid_reset");
    wait_stores(2);
    i_clk.apply_reset();
    wait_halted();
    i_chk.end_test();

    $display("tests %0d, failing tests %0d, stores checked %0d, errors %0d",
             i_chk.tests, i_chk.failed_tests, i_chk.checks, i_chk.errors);
    if (i_chk.errors == 0 && i_chk.checks > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/cpu_pkg.sv
design/reg_bus_if.sv
design/alu.sv
design/bus_filter.sv
design/register_file.sv
design/special_regs.sv
design/cu.sv
design/cpu.sv
dv/tb_clk_gen.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench, pass only if the log holds the pass line
verilator --binary -Wno-fatal --top-module cpu_tb -f verilog.f -o cpu_sim \
  && ./obj_dir/cpu_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
